// ==== hdl/tlb_pkg.sv ====
package tlb_pkg;

  // page size codes, anything but 22 counts as a 4K page
  localparam logic [5:0] PS_4K = 6'd12;
  localparam logic [5:0] PS_4M = 6'd22;

  // maintenance opcodes
  typedef enum logic [1:0] {
    TLB_OP_WRITE    = 2'd0,
    TLB_OP_INV_ALL  = 2'd1,
    TLB_OP_INV_ASID = 2'd2
  } tlb_op_e;

  // one tag, 37 bits
  typedef struct packed {
    logic        e;    // exist
    logic [9:0]  asid;
    logic        g;    // global
    logic [5:0]  ps;
    logic [18:0] vppn;
  } tlb_key_t;

endpackage

// ==== hdl/tlb_match_single.sv ====
`timescale 1ns/1ps

module tlb_match_single import tlb_pkg::*; #(
  parameter bit CLEAR_ON_RESET = 1'b1
) (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic [18:0] vppn_i,
  input  logic [9:0]  asid_i,
  input  logic        update_i,
  input  tlb_key_t    update_key_i,
  input  logic        inv_all_i,
  input  logic        inv_asid_i,
  input  logic [9:0]  inv_asid_val_i,
  output logic        match_o
);

  tlb_key_t key_q;
  logic     is_4m_q;   // decoded at write time, keeps the compare path short

  logic match_high;
  logic match_low;
  logic match_asid;
  logic inv_hit;

  // asid flush only takes private entries
  assign inv_hit = inv_all_i ||
                   (inv_asid_i && !key_q.g && (key_q.asid == inv_asid_val_i));

  always_ff @(posedge clk) begin
    if (CLEAR_ON_RESET && !rst_n_i) begin
      key_q.e <= 1'b0;
    end else if (update_i) begin
      key_q   <= update_key_i;
      is_4m_q <= (update_key_i.ps == PS_4M);
    end else if (inv_hit) begin
      key_q.e <= 1'b0;
    end
  end

  assign match_high = (key_q.vppn[18:10] == vppn_i[18:10]);
  assign match_low  = (key_q.vppn[9:0] == vppn_i[9:0]);
  assign match_asid = (key_q.asid == asid_i);

  assign match_o = key_q.e && match_high &&
                   (is_4m_q || match_low) &&   // 4M ignores low 10 bits
                   (key_q.g || match_asid);

endmodule

// ==== hdl/tlb_match.sv ====
`timescale 1ns/1ps

module tlb_match import tlb_pkg::*; #(
  parameter int unsigned ENTRY_NUM      = 16,
  parameter bit          CLEAR_ON_RESET = 1'b1
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic [18:0]          vppn_i,
  input  logic [9:0]           asid_i,
  input  logic [ENTRY_NUM-1:0] update_i,
  input  tlb_key_t             update_key_i,
  input  logic                 inv_all_i,
  input  logic                 inv_asid_i,
  input  logic [9:0]           inv_asid_val_i,
  output logic [ENTRY_NUM-1:0] match_o
);

  // key and maintenance bus fan out to every entry
  for (genvar i = 0; i < ENTRY_NUM; i++) begin : g_entry
    tlb_match_single #(
      .CLEAR_ON_RESET (CLEAR_ON_RESET)
    ) u_entry (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .vppn_i         (vppn_i),
      .asid_i         (asid_i),
      .update_i       (update_i[i]),
      .update_key_i   (update_key_i),
      .inv_all_i      (inv_all_i),
      .inv_asid_i     (inv_asid_i),
      .inv_asid_val_i (inv_asid_val_i),
      .match_o        (match_o[i])
    );
  end

endmodule

// ==== hdl/tlb_hit_encoder.sv ====
`timescale 1ns/1ps

module tlb_hit_encoder #(
  parameter int unsigned ENTRY_NUM = 16,
  localparam int unsigned IDX_W    = $clog2(ENTRY_NUM)
) (
  input  logic [ENTRY_NUM-1:0] match_i,
  output logic                 hit_o,
  output logic [IDX_W-1:0]     index_o,
  output logic                 multi_o
);

  logic [ENTRY_NUM-1:0] match_minus1;

  assign hit_o = |match_i;

  // clearing the lowest set bit leaves something only on a multi hit
  assign match_minus1 = match_i - 1'b1;
  assign multi_o      = |(match_i & match_minus1);

  // priority encode, lowest index wins
  always_comb begin
    index_o = '0;
    for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
      if (match_i[i]) begin
        index_o = IDX_W'(i);
      end
    end
  end

endmodule

// ==== hdl/tlb_lookup_stage.sv ====
`timescale 1ns/1ps

module tlb_lookup_stage (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        lookup_valid_i,
  output logic        lookup_ready_o,
  input  logic [18:0] lookup_vppn_i,
  input  logic [9:0]  lookup_asid_i,
  output logic        res_valid_o,
  input  logic        res_ready_i,
  output logic [18:0] req_vppn_o,
  output logic [9:0]  req_asid_o,
  output logic        stage_full_o
);

  logic        full_q;
  logic [18:0] vppn_q;
  logic [9:0]  asid_q;
  logic        req_fire;
  logic        res_fire;

  // single slot, refill allowed on the edge the result leaves
  assign lookup_ready_o = !full_q || res_ready_i;
  assign req_fire       = lookup_valid_i && lookup_ready_o;
  assign res_fire       = full_q && res_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (req_fire) begin
      full_q <= 1'b1;
    end else if (res_fire) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      vppn_q <= lookup_vppn_i;
      asid_q <= lookup_asid_i;
    end
  end

  assign res_valid_o  = full_q;
  assign req_vppn_o   = vppn_q;
  assign req_asid_o   = asid_q;
  assign stage_full_o = full_q;   // maintenance waits on this

endmodule

// ==== hdl/tlb_maint_ctrl.sv ====
`timescale 1ns/1ps

module tlb_maint_ctrl import tlb_pkg::*; #(
  parameter int unsigned ENTRY_NUM = 16,
  localparam int unsigned IDX_W    = $clog2(ENTRY_NUM)
) (
  input  logic                 cmd_valid_i,
  output logic                 cmd_ready_o,
  input  tlb_op_e              cmd_op_i,
  input  logic [IDX_W-1:0]     cmd_index_i,
  input  tlb_key_t             cmd_key_i,
  input  logic [9:0]           cmd_asid_i,
  input  logic                 stage_full_i,
  output logic [ENTRY_NUM-1:0] update_o,
  output tlb_key_t             update_key_o,
  output logic                 inv_all_o,
  output logic                 inv_asid_o,
  output logic [9:0]           inv_asid_val_o
);

  logic cmd_fire;

  // entries must not move under a pending result
  assign cmd_ready_o = !stage_full_i;
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  always_comb begin
    update_o   = '0;
    inv_all_o  = 1'b0;
    inv_asid_o = 1'b0;
    if (cmd_fire) begin
      case (cmd_op_i)
        TLB_OP_WRITE: begin
          update_o = ENTRY_NUM'(1) << cmd_index_i;   // one hot
        end
        TLB_OP_INV_ALL: begin
          inv_all_o = 1'b1;
        end
        TLB_OP_INV_ASID: begin
          inv_asid_o = 1'b1;
        end
        default: begin
          // opcode 3 is unused
        end
      endcase
    end
  end

  assign update_key_o   = cmd_key_i;
  assign inv_asid_val_o = cmd_asid_i;

endmodule

// ==== hdl/tlb_top.sv ====
`timescale 1ns/1ps

module tlb_top import tlb_pkg::*; #(
  parameter int unsigned ENTRY_NUM      = 16,
  parameter bit          CLEAR_ON_RESET = 1'b1,
  localparam int unsigned IDX_W         = $clog2(ENTRY_NUM)
) (
  input  logic             clk,
  input  logic             rst_n_i,
  // lookup request
  input  logic             lookup_valid_i,
  output logic             lookup_ready_o,
  input  logic [18:0]      lookup_vppn_i,
  input  logic [9:0]       lookup_asid_i,
  // lookup result
  output logic             res_valid_o,
  input  logic             res_ready_i,
  output logic             res_hit_o,
  output logic [IDX_W-1:0] res_index_o,
  output logic             res_multi_o,
  // maintenance
  input  logic             cmd_valid_i,
  output logic             cmd_ready_o,
  input  tlb_op_e          cmd_op_i,
  input  logic [IDX_W-1:0] cmd_index_i,
  input  tlb_key_t         cmd_key_i,
  input  logic [9:0]       cmd_asid_i
);

  logic [18:0]          req_vppn;
  logic [9:0]           req_asid;
  logic                 stage_full;
  logic [ENTRY_NUM-1:0] update;
  tlb_key_t             update_key;
  logic                 inv_all;
  logic                 inv_asid;
  logic [9:0]           inv_asid_val;
  logic [ENTRY_NUM-1:0] match;

  tlb_lookup_stage u_lookup_stage (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .lookup_valid_i (lookup_valid_i),
    .lookup_ready_o (lookup_ready_o),
    .lookup_vppn_i  (lookup_vppn_i),
    .lookup_asid_i  (lookup_asid_i),
    .res_valid_o    (res_valid_o),
    .res_ready_i    (res_ready_i),
    .req_vppn_o     (req_vppn),
    .req_asid_o     (req_asid),
    .stage_full_o   (stage_full)
  );

  tlb_maint_ctrl #(
    .ENTRY_NUM (ENTRY_NUM)
  ) u_maint_ctrl (
    .cmd_valid_i    (cmd_valid_i),
    .cmd_ready_o    (cmd_ready_o),
    .cmd_op_i       (cmd_op_i),
    .cmd_index_i    (cmd_index_i),
    .cmd_key_i      (cmd_key_i),
    .cmd_asid_i     (cmd_asid_i),
    .stage_full_i   (stage_full),
    .update_o       (update),
    .update_key_o   (update_key),
    .inv_all_o      (inv_all),
    .inv_asid_o     (inv_asid),
    .inv_asid_val_o (inv_asid_val)
  );

  tlb_match #(
    .ENTRY_NUM      (ENTRY_NUM),
    .CLEAR_ON_RESET (CLEAR_ON_RESET)
  ) u_match (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .vppn_i         (req_vppn),
    .asid_i         (req_asid),
    .update_i       (update),
    .update_key_i   (update_key),
    .inv_all_i      (inv_all),
    .inv_asid_i     (inv_asid),
    .inv_asid_val_i (inv_asid_val),
    .match_o        (match)
  );

  // result is combinational off the registered key
  tlb_hit_encoder #(
    .ENTRY_NUM (ENTRY_NUM)
  ) u_hit_encoder (
    .match_i (match),
    .hit_o   (res_hit_o),
    .index_o (res_index_o),
    .multi_o (res_multi_o)
  );

endmodule

// ==== testbench/tb_tlb_top.sv ====
`timescale 1ns/1ps

module tb_tlb_top import tlb_pkg::*; ();

  localparam int ENTRY_NUM = 16;
  localparam int IDX_W     = $clog2(ENTRY_NUM);
  localparam int TIMEOUT   = 20;   // cycles allowed per wait

  logic             clk;
  logic             rst_n_i;
  logic             lookup_valid_i;
  logic             lookup_ready_o;
  logic [18:0]      lookup_vppn_i;
  logic [9:0]       lookup_asid_i;
  logic             res_valid_o;
  logic             res_ready_i;
  logic             res_hit_o;
  logic [IDX_W-1:0] res_index_o;
  logic             res_multi_o;
  logic             cmd_valid_i;
  logic             cmd_ready_o;
  tlb_op_e          cmd_op_i;
  logic [IDX_W-1:0] cmd_index_i;
  tlb_key_t         cmd_key_i;
  logic [9:0]       cmd_asid_i;

  int errors = 0;
  int tests  = 0;
  int failed = 0;
  bit row_ok;

  tlb_top #(
    .ENTRY_NUM      (ENTRY_NUM),
    .CLEAR_ON_RESET (1'b1)
  ) u_tlb_top (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .lookup_valid_i (lookup_valid_i),
    .lookup_ready_o (lookup_ready_o),
    .lookup_vppn_i  (lookup_vppn_i),
    .lookup_asid_i  (lookup_asid_i),
    .res_valid_o    (res_valid_o),
    .res_ready_i    (res_ready_i),
    .res_hit_o      (res_hit_o),
    .res_index_o    (res_index_o),
    .res_multi_o    (res_multi_o),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_ready_o    (cmd_ready_o),
    .cmd_op_i       (cmd_op_i),
    .cmd_index_i    (cmd_index_i),
    .cmd_key_i      (cmd_key_i),
    .cmd_asid_i     (cmd_asid_i)
  );

  always #50 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (act_val === exp_val) else begin
      $display("Mismatch at %0d ns: %s expected %0h, got %0h", $time, name, exp_val, act_val);
      errors++;
      row_ok = 0;
    end
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0d ns: %s", $time, what);
    errors++;
    row_ok = 0;
  endtask

  task automatic drive_command(input int op, input int idx, input tlb_key_t key,
                               input int asid);
    cmd_valid_i = 1'b1;
    cmd_op_i    = tlb_op_e'(op[1:0]);
    cmd_index_i = idx[IDX_W-1:0];
    cmd_key_i   = key;
    cmd_asid_i  = asid[9:0];
  endtask

  // returns on the falling edge after the accepting edge
  task automatic wait_accept(input bit want_cmd, input bit want_lookup);
    int cycles;
    bit done;
    cycles = 0;
    done   = 0;
    while (!done && cycles < TIMEOUT) begin
      @(posedge clk);
      if ((!want_cmd || cmd_ready_o) && (!want_lookup || lookup_ready_o)) begin
        done = 1;
      end else begin
        cycles++;
      end
    end
    @(negedge clk);
    if (want_cmd) cmd_valid_i = 1'b0;
    if (want_lookup) lookup_valid_i = 1'b0;
    if (!done) report_failure("request was not accepted before the timeout");
  endtask

  task automatic run_lookup(input int vppn, input int asid, input int exp_hit,
                            input int exp_idx, input int exp_multi, input int bp,
                            input bit with_cmd);
    int cycles;
    lookup_valid_i = 1'b1;
    lookup_vppn_i  = vppn[18:0];
    lookup_asid_i  = asid[9:0];
    wait_accept(with_cmd, 1'b1);
    cycles = 0;
    while (!res_valid_o && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!res_valid_o) begin
      report_failure("no lookup result before the timeout");
    end else begin
      if (cycles != 0) begin
        report_failure("lookup result arrived later than the edge after acceptance");
      end
      check_value("res_hit_o", exp_hit, res_hit_o);
      check_value("res_index_o", exp_idx, res_index_o);
      check_value("res_multi_o", exp_multi, res_multi_o);
      repeat (bp) begin
        @(negedge clk);   // result held while both channels stall
        check_value("res_valid_o", 1, res_valid_o);
        check_value("res_hit_o", exp_hit, res_hit_o);
        check_value("res_index_o", exp_idx, res_index_o);
        check_value("res_multi_o", exp_multi, res_multi_o);
        check_value("lookup_ready_o", 0, lookup_ready_o);
        check_value("cmd_ready_o", 0, cmd_ready_o);
      end
      res_ready_i = 1'b1;
      @(negedge clk);
      res_ready_i = 1'b0;
      check_value("res_valid_o", 0, res_valid_o);
    end
  endtask

  initial begin
    int       fd;
    int       n;
    int       line_no;
    string    line;
    int       f[10];
    tlb_key_t key;
    tlb_key_t held_key;
    int       held_op;
    int       held_idx;
    int       held_asid;
    bit       pending;

    clk            = 1'b0;
    rst_n_i        = 1'b0;
    lookup_valid_i = 1'b0;
    lookup_vppn_i  = '0;
    lookup_asid_i  = '0;
    res_ready_i    = 1'b0;
    cmd_valid_i    = 1'b0;
    cmd_op_i       = TLB_OP_WRITE;
    cmd_index_i    = '0;
    cmd_key_i      = '0;
    cmd_asid_i     = '0;
    pending        = 0;
    line_no        = 0;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    row_ok = 1;
    check_value("res_valid_o", 0, res_valid_o);
    check_value("lookup_ready_o", 1, lookup_ready_o);
    check_value("cmd_ready_o", 1, cmd_ready_o);
    tests++;
    if (!row_ok) failed++;
    $display("reset state: %s", row_ok ? "ok" : "failed");

    fd = $fopen("testbench/tlb_patterns.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open testbench/tlb_patterns.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        line_no++;
        if (n > 1 && line[0] == "C") begin
          // op idx e asid g ps vppn cmd_asid with_next
          n = $sscanf(line, "C %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
          if (n != 9) report_failure($sformatf("bad command row at line %0d", line_no));
          key.e    = f[2][0];
          key.asid = f[3][9:0];
          key.g    = f[4][0];
          key.ps   = f[5][5:0];
          key.vppn = f[6][18:0];
          if (f[8] != 0) begin
            pending   = 1;   // goes out with the next lookup
            held_op   = f[0];
            held_idx  = f[1];
            held_key  = key;
            held_asid = f[7];
          end else begin
            drive_command(f[0], f[1], key, f[7]);
            wait_accept(1'b1, 1'b0);
          end
        end else if (n > 1 && line[0] == "L") begin
          // vppn asid hit index multi backpressure
          n = $sscanf(line, "L %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
          row_ok = 1;
          if (n != 6) report_failure($sformatf("bad lookup row at line %0d", line_no));
          if (pending) drive_command(held_op, held_idx, held_key, held_asid);
          run_lookup(f[0], f[1], f[2], f[3], f[4], f[5], pending);
          pending = 0;
          tests++;
          if (!row_ok) failed++;
          $display("line %0d lookup vppn=%05h asid=%03h: %s", line_no, f[0], f[1],
                   row_ok ? "ok" : "failed");
        end
      end
      $fclose(fd);
    end

    $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
hdl/tlb_pkg.sv
hdl/tlb_match_single.sv
hdl/tlb_match.sv
hdl/tlb_hit_encoder.sv
hdl/tlb_lookup_stage.sv
hdl/tlb_maint_ctrl.sv
hdl/tlb_top.sv
testbench/tb_tlb_top.sv

// ==== testbench/tlb_patterns.txt ====
# C op idx e asid g ps vppn cmd_asid with_next     (hex, op 0 write 1 inv_all 2 inv_asid)
# L vppn asid hit index multi backpressure_cycles  (hex)
L 12345 001 0 0 0 0
C 0 3 1 001 0 0c 12345 000 0
L 12345 001 1 3 0 0
L 12344 001 0 0 0 0
L 12345 002 0 0 0 0
L 52345 001 0 0 0 0
C 0 5 1 004 0 16 2a000 000 0
L 2a3ff 004 1 5 0 0
L 2a400 004 0 0 0 0
L 6a000 004 0 0 0 0
C 0 7 1 009 1 0c 33333 000 0
L 33333 0ab 1 7 0 0
L 33333 009 1 7 0 0
C 0 a 1 010 0 0c 0f0f0 000 0
C 0 c 1 3ff 1 0c 0f0f0 000 0
L 0f0f0 010 1 a 1 0
C 0 a 1 010 0 0c 0f0f1 000 0
L 0f0f0 010 1 c 0 0
C 0 1 1 001 1 0c 44444 000 0
C 2 0 0 000 0 00 00000 001 0
L 12345 001 0 0 0 0
L 44444 001 1 1 0 0
L 2a123 004 1 5 0 0
C 1 0 0 000 0 00 00000 000 0
L 44444 001 0 0 0 0
L 2a123 004 0 0 0 0
L 33333 0ab 0 0 0 0
L 0f0f0 010 0 0 0 0
C 0 2 1 055 0 0c 01234 000 0
L 01234 055 1 2 0 3
C 0 2 1 055 0 0c 07777 000 1
L 07777 055 1 2 0 0
C 1 0 0 000 0 00 00000 000 1
L 07777 055 0 0 0 2
